//--- build.f
+incdir+.
lcm_pkg.sv
pkt_stream_if.sv
report_trigger.sv
beacon_word_gen.sv
beacon_reporter.sv
lcm_report_top.sv
tb_lcm_report.sv

//--- Bender.yml
package:
  name: lcm_report

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lcm_pkg.sv
      - pkt_stream_if.sv
      - report_trigger.sv
      - beacon_word_gen.sv
      - beacon_reporter.sv
      - lcm_report_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lcm_report.sv

//--- tb_lcm_report.sv
//**********************************************************
// testbench for the local-control report stage
// directed tests of pass-through, gap claim, the skid
// path and the periodic beacon report contents
//**********************************************************
`timescale 1ns/10ps
`include "lcm_config.svh"

module tb_lcm_report
	import lcm_pkg::*;
;

	// about 200 cycles of tests with a tenfold margin
	localparam int max_cycles = 2000;
	localparam int pb = `LCM_REPORT_PERIOD_BITS;

	logic         clk;
	logic         rst_n;
	logic         in_lr_data_wr;
	logic [133:0] in_lr_data;
	logic         in_lr_data_valid;
	logic         in_lr_data_valid_wr;
	logic         hold;
	logic [47:0]  precision_time;
	logic [47:0]  local_mac_id;
	logic         direction;
	logic [31:0]  token_bucket_para;
	logic [47:0]  direct_mac_addr;
	logic [63:0]  esw_pktin_cnt, esw_pktout_cnt;
	logic [7:0]   bufm_id_cnt;
	logic [5:0]   eos_q0_used_cnt, eos_q1_used_cnt, eos_q2_used_cnt, eos_q3_used_cnt;
	logic [63:0]  eos_mdin_cnt, eos_mdout_cnt;
	logic [63:0]  goe_pktin_cnt, goe_port0out_cnt, goe_port1out_cnt, goe_discard_cnt;
	logic         out_lr_data_wr;
	logic [133:0] out_lr_data;
	logic         out_lr_data_valid;
	logic         out_lr_data_valid_wr;

	integer       seed;
	int           cyc;
	bit           time_run;
	logic [47:0]  edge_time;
	logic [47:0]  claim_time;
	logic [47:0]  last_word_time;
	int           claim_cyc;
	int           hold_fall_cyc;
	int           hold_rises;
	logic         hold_q;

	// output log and driven-word log
	logic [133:0] out_q[$];
	int           out_cyc_q[$];
	bit           out_vld_q[$];
	bit           out_vwr_q[$];
	logic [133:0] drv_q[$];
	int           drv_cyc_q[$];
	bit           drv_vwr_q[$];

	lcm_report_top UUT (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cyc       <= cyc + 1;
		edge_time <= precision_time;
	end

	//**********************************************************
	// output monitor at mid-cycle
	//**********************************************************
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_lr_data_wr) begin
				out_q.push_back(out_lr_data);
				out_cyc_q.push_back(cyc);
				out_vld_q.push_back(out_lr_data_valid);
				out_vwr_q.push_back(out_lr_data_valid_wr);
			end
			// hold rises on the same edge that captured the timestamp
			if (hold && !hold_q) begin
				claim_time = edge_time;
				claim_cyc  = cyc;
				hold_rises++;
			end
			if (!hold && hold_q)
				hold_fall_cyc = cyc;
			hold_q = hold;
		end
	end

	initial begin
		repeat (max_cycles) @(posedge clk);
		abort_test($sformatf("watchdog expired after %0d cycles", max_cycles));
	end

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic flag_mismatch(string msg);
		$display("FAIL at %0t: %s", $time, msg);
		stop_run();
	endtask

	task automatic abort_test(string msg);
		$display("%s", msg);
		stop_run();
	endtask

	// one clock step with the stream inputs idle until the caller drives a word
	task automatic tick();
		@(posedge clk);
		#1;
		in_lr_data_wr       = 1'b0;
		in_lr_data          = '0;
		in_lr_data_valid    = 1'b0;
		in_lr_data_valid_wr = 1'b0;
		if (time_run)
			precision_time = precision_time + 48'd1;
	endtask

	task automatic clear_logs();
		out_q.delete();
		out_cyc_q.delete();
		out_vld_q.delete();
		out_vwr_q.delete();
		drv_q.delete();
		drv_cyc_q.delete();
		drv_vwr_q.delete();
		hold_rises = 0;
	endtask

	task automatic wait_out(int n, int limit);
		int waited;
		waited = 0;
		while (out_q.size() < n && waited < limit) begin
			tick();
			waited++;
		end
		assert (out_q.size() >= n)
		else abort_test($sformatf("expected %0d output words but only %0d arrived in time",
			n, out_q.size()));
	endtask

	task automatic send_packet(int n, bit lead_tick);
		logic [133:0] w;
		for (int i = 0; i < n; i++) begin
			if (i > 0 || lead_tick)
				tick();
			w[133:132] = (i == 0) ? hdr_first : ((i == n - 1) ? hdr_last : hdr_middle);
			w[131:128] = $random(seed);
			w[127:0]   = {$random(seed), $random(seed), $random(seed), $random(seed)};
			in_lr_data          = w;
			in_lr_data_wr       = 1'b1;
			in_lr_data_valid    = (i == n - 1);
			in_lr_data_valid_wr = (i == n - 1);
			drv_q.push_back(w);
			drv_cyc_q.push_back(cyc);
			drv_vwr_q.push_back(i == n - 1);
			if (i == n - 1)
				last_word_time = precision_time;
		end
	endtask

	// expected report word from the documented layouts
	function automatic logic [133:0] model_word(int idx, logic [47:0] ts);
		logic [1:0]   hdr;
		logic [127:0] p;
		hdr = hdr_middle;
		p   = '0;
		case (idx)
			0: begin
				hdr      = hdr_first;
				p[95:88] = `LCM_REPORT_SMID;
			end
			2: begin
				p[127:80] = `LCM_CNC_MAC;
				p[79:32]  = local_mac_id;
				p[31:16]  = `LCM_ETHERTYPE;
				p[11:8]   = 4'he;
			end
			3: p[127:112] = `LCM_REPORT_LEN;
			5: p[95:48] = ts;
			6: begin
				p[127:80] = direct_mac_addr;
				p[79]     = direction;
				p[63:32]  = token_bucket_para;
			end
			7: p = {esw_pktin_cnt, esw_pktout_cnt};
			8: p[127:112] = {local_mac_id[7:0], bufm_id_cnt};
			9: p = {eos_mdin_cnt, eos_mdout_cnt};
			10: begin
				p[127:104] = {eos_q0_used_cnt, eos_q1_used_cnt, eos_q2_used_cnt,
					eos_q3_used_cnt};
			end
			11: p = {goe_pktin_cnt, goe_port0out_cnt};
			12: begin
				hdr = hdr_last;
				p   = {goe_port1out_cnt, goe_discard_cnt};
			end
			default: p = '0;
		endcase
		return {hdr, 4'b0, p};
	endfunction

	task automatic check_packet(int base, int delay);
		logic [133:0] exp;
		for (int i = 0; i < drv_q.size(); i++) begin
			exp = drv_q[i];
			if (exp[133:132] == hdr_first)
				exp[87:80] = `LCM_PKT_MID;
			assert (out_q[base + i] == exp)
			else flag_mismatch($sformatf("packet word %0d is %h, expected %h",
				i, out_q[base + i], exp));
			assert (out_cyc_q[base + i] == drv_cyc_q[i] + delay)
			else flag_mismatch($sformatf("packet word %0d left in cycle %0d, expected %0d",
				i, out_cyc_q[base + i], drv_cyc_q[i] + delay));
			assert (out_vwr_q[base + i] == drv_vwr_q[i] && out_vld_q[base + i] == drv_vwr_q[i])
			else flag_mismatch($sformatf("packet word %0d has wrong valid or valid_wr", i));
		end
	endtask

	task automatic check_report(int base, logic [47:0] ts);
		logic [133:0] exp;
		for (int i = 0; i < 13; i++) begin
			exp = model_word(i, ts);
			assert (out_q[base + i] == exp)
			else flag_mismatch($sformatf("report word %0d is %h, expected %h",
				i, out_q[base + i], exp));
			assert (out_cyc_q[base + i] == claim_cyc + 2 + i)
			else flag_mismatch($sformatf("report word %0d is not on consecutive cycles", i));
			assert (out_vwr_q[base + i] == (i == 12) && out_vld_q[base + i] == (i == 12))
			else flag_mismatch($sformatf("report word %0d has wrong valid or valid_wr", i));
		end
	endtask

	//**********************************************************
	// tests
	//**********************************************************
	task automatic test_reset_idle();
		clear_logs();
		for (int i = 0; i < 30; i++) begin
			tick();
			assert (!out_lr_data_wr && !out_lr_data_valid_wr && !hold)
			else flag_mismatch("output strobe or hold high without traffic or period wrap");
		end
	endtask

	task automatic test_pass_through();
		clear_logs();
		send_packet(4, 1'b1);
		wait_out(4, 10);
		check_packet(0, 1);
		repeat (3) tick();
	endtask

	task automatic test_idle_report();
		logic [47:0] w;
		w = 48'd3 << pb;
		clear_logs();
		precision_time = w - 48'd4;
		wait_out(13, 40);
		// time captured one cycle after the wrap cycle
		assert (claim_time == w + 48'd1)
		else flag_mismatch($sformatf("captured time %h, expected %h", claim_time, w + 48'd1));
		check_report(0, w + 48'd1);
		repeat (2) tick();
		assert (hold_fall_cyc == out_cyc_q[12] + 1 && !hold)
		else flag_mismatch("hold did not drop in the cycle after the last report word");
	endtask

	task automatic test_report_after_packet();
		clear_logs();
		precision_time = (48'd5 << pb) - 48'd2;
		send_packet(8, 1'b1);
		wait_out(21, 60);
		check_packet(0, 1);
		assert (claim_time == last_word_time + 48'd1)
		else flag_mismatch("report was not claimed in the first gap after the packet");
		check_report(8, claim_time);
		repeat (3) tick();
	endtask

	task automatic test_claim_collision();
		int n;
		clear_logs();
		precision_time = (48'd7 << pb) - 48'd2;
		n = 0;
		do begin
			tick();
			n++;
		end while (!hold && n < 20);
		assert (hold) else abort_test("hold never rose for the gap claim");
		// upstream starts a packet in the claim cycle itself
		send_packet(3, 1'b0);
		wait_out(16, 60);
		check_packet(0, 2);
		assert (claim_time == last_word_time + 48'd2)
		else flag_mismatch("report was not claimed after the skidded packet");
		check_report(3, claim_time);
		repeat (3) tick();
	endtask

	task automatic test_held_wrap();
		logic [47:0] w;
		w = 48'd9 << pb;
		clear_logs();
		time_run = 1'b0;
		precision_time = w - 48'd1;
		tick();
		precision_time = w;
		wait_out(13, 40);
		check_report(0, w);
		repeat (40) tick();
		assert (out_q.size() == 13 && hold_rises == 1)
		else flag_mismatch($sformatf("held wrap gave %0d words and %0d claims",
			out_q.size(), hold_rises));
	endtask

	initial begin
		seed                = 32'h0365fc6d;
		clk                 = 1'b0;
		rst_n               = 1'b0;
		time_run            = 1'b1;
		hold_q              = 1'b0;
		hold_rises          = 0;
		in_lr_data_wr       = 1'b0;
		in_lr_data          = '0;
		in_lr_data_valid    = 1'b0;
		in_lr_data_valid_wr = 1'b0;
		precision_time      = 48'h100;
		local_mac_id        = {$random(seed), $random(seed)};
		direction           = $random(seed);
		token_bucket_para   = $random(seed);
		direct_mac_addr     = {$random(seed), $random(seed)};
		esw_pktin_cnt       = {$random(seed), $random(seed)};
		esw_pktout_cnt      = {$random(seed), $random(seed)};
		bufm_id_cnt         = $random(seed);
		eos_q0_used_cnt     = $random(seed);
		eos_q1_used_cnt     = $random(seed);
		eos_q2_used_cnt     = $random(seed);
		eos_q3_used_cnt     = $random(seed);
		eos_mdin_cnt        = {$random(seed), $random(seed)};
		eos_mdout_cnt       = {$random(seed), $random(seed)};
		goe_pktin_cnt       = {$random(seed), $random(seed)};
		goe_port0out_cnt    = {$random(seed), $random(seed)};
		goe_port1out_cnt    = {$random(seed), $random(seed)};
		goe_discard_cnt     = {$random(seed), $random(seed)};
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_reset_idle();
		test_pass_through();
		test_idle_report();
		test_report_after_packet();
		test_claim_collision();
		test_held_wrap();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- lcm_report_top.sv
//**********************************************************
// local-control report stage, top level
// stamps forwarded packets and injects a periodic beacon
// report between them
//**********************************************************
`timescale 1ns/10ps

module lcm_report_top
	import lcm_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	// upstream packet stream
	input  logic         in_lr_data_wr,
	input  logic [133:0] in_lr_data,
	input  logic         in_lr_data_valid,
	input  logic         in_lr_data_valid_wr,
	output logic         hold,
	input  logic [47:0]  precision_time,
	input  logic [47:0]  local_mac_id,
	// beacon settings
	input  logic         direction,
	input  logic [31:0]  token_bucket_para,
	input  logic [47:0]  direct_mac_addr,
	// status counters
	input  logic [63:0]  esw_pktin_cnt,
	input  logic [63:0]  esw_pktout_cnt,
	input  logic [7:0]   bufm_id_cnt,
	input  logic [5:0]   eos_q0_used_cnt,
	input  logic [5:0]   eos_q1_used_cnt,
	input  logic [5:0]   eos_q2_used_cnt,
	input  logic [5:0]   eos_q3_used_cnt,
	input  logic [63:0]  eos_mdin_cnt,
	input  logic [63:0]  eos_mdout_cnt,
	input  logic [63:0]  goe_pktin_cnt,
	input  logic [63:0]  goe_port0out_cnt,
	input  logic [63:0]  goe_port1out_cnt,
	input  logic [63:0]  goe_discard_cnt,
	// downstream packet stream
	output logic         out_lr_data_wr,
	output logic [133:0] out_lr_data,
	output logic         out_lr_data_valid,
	output logic         out_lr_data_valid_wr
);

	status_cnt_t cnt;
	beacon_cfg_t cfg;
	logic        report_pending;
	logic        report_sent;
	logic [3:0]  word_idx;
	logic [47:0] snapshot_time;
	pkt_word_t   report_word;

	pkt_stream_if out_stream ();

	assign cnt = '{
		sw_pkt_in:   esw_pktin_cnt,
		sw_pkt_out:  esw_pktout_cnt,
		sw_buf_id:   bufm_id_cnt,
		sch_q0_used: eos_q0_used_cnt,
		sch_q1_used: eos_q1_used_cnt,
		sch_q2_used: eos_q2_used_cnt,
		sch_q3_used: eos_q3_used_cnt,
		sch_md_in:   eos_mdin_cnt,
		sch_md_out:  eos_mdout_cnt,
		out_pkt_in:  goe_pktin_cnt,
		out_port0:   goe_port0out_cnt,
		out_port1:   goe_port1out_cnt,
		out_discard: goe_discard_cnt
	};

	assign cfg = '{
		direction:    direction,
		token_bucket: token_bucket_para,
		direct_mac:   direct_mac_addr
	};

	report_trigger u_trigger (
		.clk            (clk),
		.rst_n          (rst_n),
		.precision_time (precision_time),
		.report_sent    (report_sent),
		.report_pending (report_pending)
	);

	beacon_word_gen u_word_gen (
		.word_idx      (word_idx),
		.snapshot_time (snapshot_time),
		.local_mac     (local_mac_id),
		.cfg           (cfg),
		.cnt           (cnt),
		.report_word   (report_word)
	);

	beacon_reporter u_reporter (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_wr          (in_lr_data_wr),
		.in_data        (pkt_word_t'(in_lr_data)),
		.in_valid       (in_lr_data_valid),
		.in_valid_wr    (in_lr_data_valid_wr),
		.precision_time (precision_time),
		.report_pending (report_pending),
		.report_sent    (report_sent),
		.hold           (hold),
		.word_idx       (word_idx),
		.snapshot_time  (snapshot_time),
		.report_word    (report_word),
		.out_stream     (out_stream.source)
	);

	assign out_lr_data_wr       = out_stream.wr;
	assign out_lr_data          = out_stream.data;
	assign out_lr_data_valid    = out_stream.valid;
	assign out_lr_data_valid_wr = out_stream.valid_wr;

endmodule

//--- beacon_reporter.sv
//**********************************************************
// beacon reporter
// forwards the packet stream with the module id stamped,
// claims idle gaps under hold and sends the 13-word report
//**********************************************************
`timescale 1ns/10ps
`include "lcm_config.svh"

module beacon_reporter
	import lcm_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         in_wr,
	input  pkt_word_t    in_data,
	input  logic         in_valid,
	input  logic         in_valid_wr,
	input  logic [47:0]  precision_time,
	input  logic         report_pending,
	output logic         report_sent,
	output logic         hold,
	output logic [3:0]   word_idx,
	output logic [47:0]  snapshot_time,
	input  pkt_word_t    report_word,
	pkt_stream_if.source out_stream
);

	localparam logic [3:0] last_idx = 4'd12;

	typedef enum logic [2:0] {
		st_idle,
		st_claim,
		st_skid,
		st_forward,
		st_report
	} state_t;

	state_t    state;
	pkt_word_t in_stamped;
	logic      claim_go;

	logic      out_wr;
	pkt_word_t out_data;
	logic      out_valid;
	logic      out_valid_wr;

	// holds the word that slipped in during a claim
	logic      skid_wr;
	pkt_word_t skid_data;
	logic      skid_valid;
	logic      skid_valid_wr;

	// first words carry the local module id
	always_comb begin
		in_stamped = in_data;
		if (in_data.hdr == hdr_first)
			in_stamped.payload[87:80] = `LCM_PKT_MID;
	end

	// no claim in the cycle the request is being cleared
	assign claim_go = report_pending && !report_sent && !in_wr;

	//**********************************************************
	// control FSM
	//**********************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= st_idle;
			hold          <= 1'b0;
			report_sent   <= 1'b0;
			word_idx      <= 4'd0;
			out_wr        <= 1'b0;
			out_valid     <= 1'b0;
			out_valid_wr  <= 1'b0;
			skid_wr       <= 1'b0;
			skid_valid    <= 1'b0;
			skid_valid_wr <= 1'b0;
		end else begin
			report_sent <= 1'b0;
			case (state)
				st_idle: begin
					out_wr       <= in_wr;
					out_valid    <= in_valid;
					out_valid_wr <= in_valid_wr;
					hold         <= claim_go;
					if (in_wr && in_data.hdr != hdr_last)
						state <= st_forward;
					else if (claim_go)
						state <= st_claim;
				end
				st_claim: begin
					out_wr       <= 1'b0;
					out_valid    <= 1'b0;
					out_valid_wr <= 1'b0;
					if (in_wr) begin
						// upstream was already sending so the gap goes back
						hold          <= 1'b0;
						skid_wr       <= 1'b1;
						skid_valid    <= in_valid;
						skid_valid_wr <= in_valid_wr;
						state         <= st_skid;
					end else begin
						state <= st_report;
					end
				end
				st_skid: begin
					out_wr        <= skid_wr;
					out_valid     <= skid_valid;
					out_valid_wr  <= skid_valid_wr;
					skid_wr       <= in_wr;
					skid_valid    <= in_valid;
					skid_valid_wr <= in_valid_wr;
					if (skid_wr && skid_data.hdr == hdr_last && !in_wr)
						state <= st_idle;
				end
				st_forward: begin
					out_wr       <= in_wr;
					out_valid    <= in_valid;
					out_valid_wr <= in_valid_wr;
					if (in_wr && in_data.hdr == hdr_last)
						state <= st_idle;
				end
				st_report: begin
					out_wr       <= 1'b1;
					out_valid    <= (word_idx == last_idx);
					out_valid_wr <= (word_idx == last_idx);
					if (word_idx == last_idx) begin
						// hold drops from idle one cycle later
						report_sent <= 1'b1;
						word_idx    <= 4'd0;
						state       <= st_idle;
					end else begin
						word_idx <= word_idx + 4'd1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	//**********************************************************
	// datapath
	//**********************************************************
	always_ff @(posedge clk) begin
		case (state)
			st_report: out_data <= report_word;
			st_skid:   out_data <= skid_data;
			default:   out_data <= in_stamped;
		endcase
		if (state == st_claim || state == st_skid)
			skid_data <= in_stamped;
		if (state == st_idle && claim_go)
			snapshot_time <= precision_time;
	end

	assign out_stream.wr       = out_wr;
	assign out_stream.data     = out_data;
	assign out_stream.valid    = out_valid;
	assign out_stream.valid_wr = out_valid_wr;

	// upstream honours hold and never sends during a report
	a_no_input_in_report: assert property (
		@(posedge clk) disable iff (!rst_n) (state == st_report) |-> !in_wr
	);

	a_word_idx_range: assert property (
		@(posedge clk) disable iff (!rst_n) word_idx <= last_idx
	);

endmodule

//--- beacon_word_gen.sv
//**********************************************************
// beacon report word generator
// builds report word N from the captured timestamp,
// beacon settings and status counters
//**********************************************************
`timescale 1ns/10ps
`include "lcm_config.svh"

module beacon_word_gen
	import lcm_pkg::*;
(
	input  logic [3:0]  word_idx,
	input  logic [47:0] snapshot_time,
	input  logic [47:0] local_mac,
	input  beacon_cfg_t cfg,
	input  status_cnt_t cnt,
	output pkt_word_t   report_word
);

	always_comb begin
		report_word.hdr     = hdr_middle;
		report_word.rsv     = 4'b0;
		report_word.payload = '0;
		case (word_idx)
			4'd0: begin
				report_word.hdr     = hdr_first;
				report_word.payload = {32'b0, `LCM_REPORT_SMID, 88'b0};
			end
			// word 1 carries an empty payload
			4'd2: begin
				report_word.payload = {`LCM_CNC_MAC, local_mac, `LCM_ETHERTYPE,
					4'h0, 4'he, 8'h00};
			end
			4'd3: report_word.payload = {`LCM_REPORT_LEN, 112'b0};
			// word 4 is all zero
			4'd5: report_word.payload = {32'b0, snapshot_time, 48'b0};
			4'd6: begin
				report_word.payload = {cfg.direct_mac, cfg.direction, 15'b0,
					cfg.token_bucket, 32'b0};
			end
			//**********************************************************
			// counters
			//**********************************************************
			4'd7: report_word.payload = {cnt.sw_pkt_in, cnt.sw_pkt_out};
			4'd8: report_word.payload = {local_mac[7:0], cnt.sw_buf_id, 112'b0};
			4'd9: report_word.payload = {cnt.sch_md_in, cnt.sch_md_out};
			4'd10: begin
				report_word.payload = {cnt.sch_q0_used, cnt.sch_q1_used,
					cnt.sch_q2_used, cnt.sch_q3_used, 104'b0};
			end
			4'd11: report_word.payload = {cnt.out_pkt_in, cnt.out_port0};
			4'd12: begin
				// closing word of the report
				report_word.hdr     = hdr_last;
				report_word.payload = {cnt.out_port1, cnt.out_discard};
			end
			default: report_word.payload = '0;
		endcase
	end

endmodule

//--- report_trigger.sv
//**********************************************************
// report trigger
// flags a report request at each period wrap of the
// precision clock and holds it until the report is sent
//**********************************************************
`timescale 1ns/10ps
`include "lcm_config.svh"

module report_trigger (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [47:0] precision_time,
	input  logic        report_sent,
	output logic        report_pending
);

	localparam int period_bits = `LCM_REPORT_PERIOD_BITS;

	logic wrap;
	logic wrap_q;

	assign wrap = (precision_time[period_bits-1:0] == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// time at zero out of reset is not a real boundary
			wrap_q         <= 1'b1;
			report_pending <= 1'b0;
		end else begin
			wrap_q <= wrap;
			// a new boundary wins over a clear in the same cycle
			if (wrap && !wrap_q)
				report_pending <= 1'b1;
			else if (report_sent)
				report_pending <= 1'b0;
		end
	end

	// the reporter only completes a report that was requested
	a_sent_when_pending: assert property (
		@(posedge clk) disable iff (!rst_n) report_sent |-> report_pending
	);

endmodule

//--- pkt_stream_if.sv
//**********************************************************
// packet word stream
// word strobe, data and end-of-packet verdict
//**********************************************************
`timescale 1ns/10ps

interface pkt_stream_if
	import lcm_pkg::*;
();

	logic      wr;
	pkt_word_t data;
	// verdict of the packet, qualified by valid_wr
	logic      valid;
	logic      valid_wr;

	modport source (
		output wr,
		output data,
		output valid,
		output valid_wr
	);

	modport sink (
		input wr,
		input data,
		input valid,
		input valid_wr
	);

endinterface

//--- lcm_pkg.sv
//**********************************************************
// local-control report stage types
// packet word layout, header codes and status counters
//**********************************************************
package lcm_pkg;

	// one word of the 134-bit packet stream
	typedef struct packed {
		logic [1:0]   hdr;
		logic [3:0]   rsv;
		logic [127:0] payload;
	} pkt_word_t;

	// header codes in the top two bits of a word
	localparam logic [1:0] hdr_first  = 2'b01;
	localparam logic [1:0] hdr_middle = 2'b11;
	localparam logic [1:0] hdr_last   = 2'b10;

	// status counters gathered from the switch datapath
	typedef struct packed {
		// switching block
		logic [63:0] sw_pkt_in;
		logic [63:0] sw_pkt_out;
		logic [7:0]  sw_buf_id;
		// scheduler queue use and metadata
		logic [5:0]  sch_q0_used;
		logic [5:0]  sch_q1_used;
		logic [5:0]  sch_q2_used;
		logic [5:0]  sch_q3_used;
		logic [63:0] sch_md_in;
		logic [63:0] sch_md_out;
		// output stage
		logic [63:0] out_pkt_in;
		logic [63:0] out_port0;
		logic [63:0] out_port1;
		logic [63:0] out_discard;
	} status_cnt_t;

	// beacon settings reported in word 6
	typedef struct packed {
		logic        direction;
		logic [31:0] token_bucket;
		logic [47:0] direct_mac;
	} beacon_cfg_t;

endpackage

//--- lcm_config.svh
//**********************************************************
// local-control report stage configuration
// report period, module ids and report frame constants
//**********************************************************
`ifndef LCM_CONFIG_SVH
`define LCM_CONFIG_SVH

// low precision-time bits that wrap once per report period
`define LCM_REPORT_PERIOD_BITS 20

// module id stamped into forwarded first words
`define LCM_PKT_MID 8'd1

// source module id carried in the report's first word
`define LCM_REPORT_SMID 8'd128

// controller (CNC) MAC address, destination of the report
`define LCM_CNC_MAC 48'h010203040506

// ethertype of the report frame
`define LCM_ETHERTYPE 16'h88f7

// length field of the report frame
`define LCM_REPORT_LEN 16'd176

`endif
